/* verilog.f */
+incdir+logic
logic/bitstream_pkg.sv
logic/bitfield_datapath.sv
logic/stream_base_regs.sv
logic/stream_fsm.sv
logic/bitstream_coproc.sv
testbench/bitstream_coproc_checker.sv
testbench/tb_bitstream_coproc.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the bit-stream coprocessor testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f verilog.f \
  --top-module tb_bitstream_coproc -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

output=$(./obj_dir/Vtb_bitstream_coproc)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$output" | grep -qx "TEST RESULT: PASS"; then
  exit 0
fi
exit 1

/* testbench/bitstream_patterns.txt */
# P addr word : memory preload
# kind f3 rs1 rs2 kill exp0 exp1 : C config, L load, S store, U unknown opcode (hex)
# exp0 is the load data or the first written word, exp1 the second written word
P 00000100 89abcdef
P 00000104 01234567
P 00000108 f0f0f0f0
P 00000300 00000000
P 00000304 ffffffff
P 00000308 12345678
C 6 00000000 00000100 0 00000000 00000000
C 5 00000200 00000000 0 00000000 00000000
C 7 00000300 00000100 0 00000000 00000000
L 0 00000000 00000007 0 000000ef 00000000
L 0 0000001f 0000000f 0 00008acf 00000000
L 0 00000028 0000001f 0 f0012345 00000000
S 0 0000001c 00000007 0 00000000 fffffff0
S 1 0000001c 00000007 0 f0000000 ffffffff
L 0 00000004 00000003 0 0000000e 00000000
S 2 00000028 0000000f 0 ffbcdeff 12345678
L 0 00000000 00000007 1 00000000 00000000
L 0 00000000 00000007 0 000000ef 00000000
S 0 00000028 0000000f 1 00000000 00000000
C 6 00000000 00000300 0 00000000 00000000
L 0 00000020 0000001f 0 ffbcdeff 00000000
U 0 00000000 00000000 0 00000000 00000000

/* testbench/tb_bitstream_coproc.sv */
`timescale 1ns/1ps
`include "bitstream_config.svh"

module tb_bitstream_coproc import bitstream_pkg::*; ();

  localparam int TIMEOUT      = 200;
  localparam int QUIET_CYCLES = 8;

  logic       clk_i = 1'b0;
  logic       rst_ni;
  logic       issue_valid;
  logic       issue_ready;
  instr_u     issue_instr;
  word_t      issue_rs1;
  word_t      issue_rs2;
  id_t        issue_id;
  logic       issue_accept;
  logic       issue_writeback;
  logic       commit_valid;
  logic       commit_kill;
  logic       mem_valid;
  addr_t      mem_addr;
  logic       mem_we;
  word_t      mem_wdata;
  logic       mem_last;
  logic       mem_result_valid = 1'b0;
  word_t      mem_rdata = '0;
  logic       result_valid;
  logic       result_ready;
  id_t        result_id;
  logic [4:0] result_rd;
  logic       result_we;
  word_t      result_data;

  word_t       mem_model [addr_t];
  addr_t       log_addr [$];     // one entry per answered request
  word_t       log_data [$];
  logic        log_we [$];
  logic        log_last [$];
  logic        mem_pending = 1'b0;
  logic [1:0]  mem_delay = 2'd0;
  logic [1:0]  delay_now;
  logic [31:0] mem_rng = 32'd44874;
  logic [31:0] ctl_rng = 32'd44874;
  addr_t       load_base;
  addr_t       store_base;
  int          test_num;
  int          check_count;
  int          error_count;
  logic        timed_out;

  always #2 clk_i = ~clk_i;

  bitstream_coproc bitstream_coproc_i (.*);

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    return y ^ (y << 5);
  endfunction

  // unwritten words read back as a pattern of their own address
  function automatic word_t read_word(input addr_t a);
    return mem_model.exists(a) ? mem_model[a] : (a ^ 32'ha5a5_5a5a);
  endfunction

  function automatic instr_u make_instr(input logic [6:0] opc, input logic [2:0] f3,
                                        input logic [4:0] rd);
    return instr_u'({7'd0, 5'd2, 5'd1, f3, rd, opc});
  endfunction

  // memory model, answers each request after 0 to 3 idle cycles
  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mem_result_valid <= 1'b0;
      mem_pending      <= 1'b0;
    end else if (mem_result_valid) begin
      mem_result_valid <= 1'b0;           // this edge ended the request
      mem_pending      <= 1'b0;
    end else if (!mem_valid) begin
      mem_pending <= 1'b0;                // request dropped by a kill
    end else begin
      if (mem_pending) begin
        delay_now = mem_delay;
      end else begin
        mem_rng   = xorshift32(mem_rng);
        delay_now = mem_rng[1:0];
      end
      mem_pending <= 1'b1;
      if (delay_now == 2'd0) begin
        mem_result_valid <= 1'b1;
        log_addr.push_back(mem_addr);
        log_we.push_back(mem_we);
        log_last.push_back(mem_last);
        if (mem_we) begin
          mem_model[mem_addr] = mem_wdata;
          log_data.push_back(mem_wdata);
        end else begin
          mem_rdata <= read_word(mem_addr);
          log_data.push_back(read_word(mem_addr));
        end
      end else begin
        mem_delay <= delay_now - 2'd1;
      end
    end
  end

  task automatic check_result(input string name, input word_t exp, input word_t got);
    check_count++;
    if (exp !== got) begin
      $display("Mismatch at %0t: %s expected %h got %h", $time, name, exp, got);
      error_count++;
    end
  endtask

  task automatic check_addr(input string name, input addr_t exp, input addr_t got);
    check_count++;
    if (exp !== got) begin
      $display("Mismatch at %0t: %s expected %h got %h", $time, name, exp, got);
      error_count++;
    end
  endtask

  task automatic check_id(input string name, input id_t exp, input id_t got);
    check_count++;
    if (exp !== got) begin
      $display("Mismatch at %0t: %s expected %h got %h", $time, name, exp, got);
      error_count++;
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic got);
    check_count++;
    if (exp !== got) begin
      $display("Mismatch at %0t: %s expected %b got %b", $time, name, exp, got);
      error_count++;
    end
  endtask

  task automatic check_write(input addr_t exp_addr, input word_t exp_data,
                             input addr_t got_addr, input word_t got_data);
    check_addr("mem_addr of write", exp_addr, got_addr);
    check_result("mem_wdata", exp_data, got_data);
  endtask

  task automatic wait_ready(output logic ok);
    int cycles;
    ok     = 1'b0;
    cycles = 0;
    while (!ok && cycles < TIMEOUT) begin
      @(negedge clk_i);
      ok = issue_ready;
      cycles++;
    end
    if (!ok) begin
      $display("Timeout at %0t: issue_ready stayed low for %0d cycles", $time, TIMEOUT);
      error_count++;
      timed_out = 1'b1;
    end
  endtask

  task automatic wait_result(output logic ok);
    int cycles;
    ok     = 1'b0;
    cycles = 0;
    while (!ok && cycles < TIMEOUT) begin
      @(negedge clk_i);
      ok = result_valid;
      cycles++;
    end
    if (!ok) begin
      $display("Timeout at %0t: no result_valid within %0d cycles", $time, TIMEOUT);
      error_count++;
      timed_out = 1'b1;
    end
  endtask

  // no result may appear and nothing may be written
  task automatic check_quiet(input logic allow_reads);
    logic ok;
    repeat (QUIET_CYCLES) begin
      @(negedge clk_i);
      check_flag("issue_ready", 1'b1, issue_ready);
      if (result_valid) begin
        $display("Error at %0t: a result appeared for an instruction that must not retire",
                 $time);
        error_count++;
      end
    end
    wait_ready(ok);
    foreach (log_we[i]) begin
      if (log_we[i] || !allow_reads) begin
        $display("Error at %0t: unexpected memory request to address %h", $time, log_addr[i]);
        error_count++;
      end
    end
  endtask

  task automatic check_accesses(input logic [7:0] kind, input addr_t base,
                                input word_t e0, input word_t e1);
    int expected_n;
    expected_n = (kind == "C") ? 0 : (kind == "L") ? 2 : 4;
    if (log_addr.size() != expected_n) begin
      $display("Error at %0t: %0d memory requests seen where %0d were due", $time,
               log_addr.size(), expected_n);
      error_count++;
      return;
    end
    if (expected_n == 0) begin
      return;
    end
    check_addr("mem_addr of read 0", base, log_addr[0]);
    check_addr("mem_addr of read 1", base + 32'd4, log_addr[1]);
    check_flag("mem_we of read 0", 1'b0, log_we[0]);
    check_flag("mem_we of read 1", 1'b0, log_we[1]);
    check_flag("mem_last of read 0", 1'b0, log_last[0]);
    check_flag("mem_last of read 1", kind == "L", log_last[1]);
    if (kind == "S") begin
      check_flag("mem_we of write 0", 1'b1, log_we[2]);
      check_flag("mem_we of write 1", 1'b1, log_we[3]);
      check_write(base, e0, log_addr[2], log_data[2]);
      check_write(base + 32'd4, e1, log_addr[3], log_data[3]);
      check_flag("mem_last of write 0", 1'b0, log_last[2]);
      check_flag("mem_last of write 1", 1'b1, log_last[3]);
    end
  endtask

  task automatic run_test(input logic [7:0] kind, input logic [2:0] f3, input word_t rs1v,
                          input word_t rs2v, input logic kill, input word_t e0,
                          input word_t e1);
    int         errors_before;
    int         delay;
    int         hold;
    logic       ok;
    logic [6:0] opc;
    addr_t      base;
    test_num++;
    errors_before = error_count;
    log_addr.delete();
    log_data.delete();
    log_we.delete();
    log_last.delete();
    ctl_rng = xorshift32(ctl_rng);
    delay   = int'(ctl_rng[1:0]);
    hold    = int'(ctl_rng[9:8]);
    opc     = (kind == "S") ? `BS_OPCODE_RMST : (kind == "U") ? 7'b111_1011 : `BS_OPCODE_RMLD;
    base    = ((kind == "S") ? store_base : load_base) + (rs1v >> 5) * 32'd4;
    wait_ready(ok);
    if (ok) begin
      @(posedge clk_i);
      issue_valid  <= 1'b1;
      issue_instr  <= make_instr(opc, f3, test_num[4:0]);
      issue_rs1    <= rs1v;
      issue_rs2    <= rs2v;
      issue_id     <= test_num[3:0];
      commit_valid <= (delay == 0) && (kind != "U");
      commit_kill  <= kill;
      @(negedge clk_i);
      check_flag("issue_accept", kind != "U", issue_accept);
      check_flag("issue_writeback", kind == "L", issue_writeback);
      @(posedge clk_i);                    // issue edge
      issue_valid  <= 1'b0;
      commit_valid <= 1'b0;
      if (kind != "U" && delay != 0) begin
        repeat (delay - 1) @(posedge clk_i);
        commit_valid <= 1'b1;
        commit_kill  <= kill;
        @(posedge clk_i);
        commit_valid <= 1'b0;
      end
      if (kind == "U" || kill) begin
        check_quiet(kind != "U");
      end else begin
        wait_result(ok);
        if (ok) begin
          check_flag("result_we", kind == "L", result_we);
          check_id("result_id", test_num[3:0], result_id);
          check_result("result_rd", word_t'(test_num[4:0]), word_t'(result_rd));
          if (kind == "L") begin
            check_result("result_data", e0, result_data);
          end
          repeat (hold) begin
            @(posedge clk_i);
            @(negedge clk_i);
            check_flag("result_valid under back-pressure", 1'b1, result_valid);
          end
          @(posedge clk_i);
          result_ready <= 1'b1;
          @(posedge clk_i);
          result_ready <= 1'b0;
          check_accesses(kind, base, e0, e1);
          if (kind == "C" && f3[0]) begin
            store_base = rs1v;
          end
          if (kind == "C" && f3[1]) begin
            load_base = rs2v;
          end
        end
      end
      commit_kill <= 1'b0;
    end
    $display("test %0d (%c f3=%0d kill=%0d): %s", test_num, kind, f3, kill,
             (error_count == errors_before) ? "ok" : "errors");
  endtask

  initial begin
    int          fd;
    int          n;
    string       text;
    logic [7:0]  kind;
    logic [31:0] a;
    logic [31:0] d;
    logic [31:0] f3;
    logic [31:0] rs1v;
    logic [31:0] rs2v;
    logic [31:0] killv;
    logic [31:0] e0;
    logic [31:0] e1;
    issue_valid  = 1'b0;
    issue_instr  = '0;
    issue_rs1    = '0;
    issue_rs2    = '0;
    issue_id     = '0;
    commit_valid = 1'b0;
    commit_kill  = 1'b0;
    result_ready = 1'b0;
    load_base    = '0;
    store_base   = '0;
    test_num     = 0;
    check_count  = 0;
    error_count  = 0;
    timed_out    = 1'b0;
    rst_ni       = 1'b0;
    repeat (2) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(posedge clk_i);
    fd = $fopen("testbench/bitstream_patterns.txt", "r");
    if (fd == 0) begin
      $display("Error: cannot open testbench/bitstream_patterns.txt");
      error_count++;
    end else begin
      while (!timed_out) begin
        n = $fscanf(fd, " %c", kind);
        if (n != 1) begin
          break;
        end
        if (kind == "#") begin
          n = $fgets(text, fd);
        end else if (kind == "P") begin
          n = $fscanf(fd, "%h %h", a, d);
          mem_model[a] = d;
        end else begin
          n = $fscanf(fd, "%h %h %h %h %h %h", f3, rs1v, rs2v, killv, e0, e1);
          if (n != 6) begin
            $display("Error: malformed pattern line of kind %c", kind);
            error_count++;
            break;
          end
          run_test(kind, f3[2:0], rs1v, rs2v, killv[0], e0, e1);
        end
      end
      $fclose(fd);
    end
    $display("%0d tests, %0d checks, %0d errors", test_num, check_count, error_count);
    if (error_count == 0 && test_num > 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

/* testbench/bitstream_coproc_checker.sv */
`timescale 1ns/1ps

module bitstream_coproc_checker import bitstream_pkg::*; (
  input logic       clk_i,
  input logic       rst_ni,
  input logic       issue_ready,
  input logic       commit_valid,
  input logic       commit_kill,
  input logic       mem_valid,
  input addr_t      mem_addr,
  input logic       mem_we,
  input word_t      mem_wdata,
  input logic       mem_last,
  input logic       mem_result_valid,
  input logic       result_valid,
  input logic       result_ready,
  input id_t        result_id,
  input logic [4:0] result_rd,
  input logic       result_we,
  input word_t      result_data
);

  // a kill may drop the request before it is answered
  mem_request_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    mem_valid && !mem_result_valid && !(commit_valid && commit_kill) |=>
      mem_valid && $stable(mem_addr) && $stable(mem_we) && $stable(mem_wdata) &&
      $stable(mem_last))
    else $error("memory request changed before its result");

  result_held: assert property (@(posedge clk_i) disable iff (!rst_ni)
    result_valid && !result_ready |=>
      result_valid && $stable(result_id) && $stable(result_rd) && $stable(result_we) &&
      $stable(result_data))
    else $error("result dropped or changed before result_ready");

  busy_not_ready: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (mem_valid || result_valid) |-> !issue_ready)
    else $error("issue_ready high while a request or result is pending");

  quiet_after_reset: assert property (@(posedge clk_i)
    $rose(rst_ni) |-> !mem_valid && !result_valid)
    else $error("request or result active right after reset");

endmodule

bind bitstream_coproc bitstream_coproc_checker bitstream_coproc_checker_i (
  .clk_i            (clk_i),
  .rst_ni           (rst_ni),
  .issue_ready      (issue_ready),
  .commit_valid     (commit_valid),
  .commit_kill      (commit_kill),
  .mem_valid        (mem_valid),
  .mem_addr         (mem_addr),
  .mem_we           (mem_we),
  .mem_wdata        (mem_wdata),
  .mem_last         (mem_last),
  .mem_result_valid (mem_result_valid),
  .result_valid     (result_valid),
  .result_ready     (result_ready),
  .result_id        (result_id),
  .result_rd        (result_rd),
  .result_we        (result_we),
  .result_data      (result_data)
);

/* logic/bitstream_coproc.sv */
`timescale 1ns/1ps

module bitstream_coproc import bitstream_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       issue_valid,
  output logic       issue_ready,
  input  instr_u     issue_instr,
  input  word_t      issue_rs1,
  input  word_t      issue_rs2,
  input  id_t        issue_id,
  output logic       issue_accept,
  output logic       issue_writeback,
  input  logic       commit_valid,
  input  logic       commit_kill,      // with commit_valid, drop the instruction
  output logic       mem_valid,
  output addr_t      mem_addr,
  output logic       mem_we,
  output word_t      mem_wdata,
  output logic       mem_last,
  input  logic       mem_result_valid,
  input  word_t      mem_rdata,
  output logic       result_valid,
  input  logic       result_ready,
  output id_t        result_id,
  output logic [4:0] result_rd,
  output logic       result_we,
  output word_t      result_data
);

  logic    cfg_we;
  logic    rd_lo_we;
  logic    rd_hi_we;
  logic    shadow_we;
  instr_u  instr;         // operands of the instruction in flight
  word_t   rs1;
  word_t   rs2;
  addr_t   load_addr;
  addr_t   store_addr;
  word_t   load_data;
  window_t store_window;

  stream_fsm stream_fsm_i (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .issue_valid      (issue_valid),
    .issue_ready      (issue_ready),
    .issue_instr      (issue_instr),
    .issue_rs1        (issue_rs1),
    .issue_rs2        (issue_rs2),
    .issue_id         (issue_id),
    .issue_accept     (issue_accept),
    .issue_writeback  (issue_writeback),
    .commit_valid     (commit_valid),
    .commit_kill      (commit_kill),
    .mem_valid        (mem_valid),
    .mem_addr         (mem_addr),
    .mem_we           (mem_we),
    .mem_wdata        (mem_wdata),
    .mem_last         (mem_last),
    .mem_result_valid (mem_result_valid),
    .result_valid     (result_valid),
    .result_ready     (result_ready),
    .result_id        (result_id),
    .result_rd        (result_rd),
    .result_we        (result_we),
    .result_data      (result_data),
    .load_addr        (load_addr),
    .store_addr       (store_addr),
    .load_data        (load_data),
    .store_window     (store_window),
    .cfg_we           (cfg_we),
    .rd_lo_we         (rd_lo_we),
    .rd_hi_we         (rd_hi_we),
    .shadow_we        (shadow_we),
    .instr            (instr),
    .rs1              (rs1),
    .rs2              (rs2)
  );

  stream_base_regs stream_base_regs_i (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .cfg_we     (cfg_we),
    .instr      (instr),
    .rs1        (rs1),
    .rs2        (rs2),
    .load_addr  (load_addr),
    .store_addr (store_addr)
  );

  bitfield_datapath bitfield_datapath_i (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .rd_lo_we     (rd_lo_we),
    .rd_hi_we     (rd_hi_we),
    .shadow_we    (shadow_we),
    .mem_rdata    (mem_rdata),
    .instr        (instr),
    .rs1          (rs1),
    .rs2          (rs2),
    .load_data    (load_data),
    .store_window (store_window)
  );

endmodule

/* logic/stream_fsm.sv */
`timescale 1ns/1ps
`include "bitstream_config.svh"

module stream_fsm import bitstream_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       issue_valid,
  output logic       issue_ready,
  input  instr_u     issue_instr,
  input  word_t      issue_rs1,
  input  word_t      issue_rs2,
  input  id_t        issue_id,
  output logic       issue_accept,
  output logic       issue_writeback,
  input  logic       commit_valid,
  input  logic       commit_kill,
  output logic       mem_valid,
  output addr_t      mem_addr,
  output logic       mem_we,
  output word_t      mem_wdata,
  output logic       mem_last,
  input  logic       mem_result_valid,
  output logic       result_valid,
  input  logic       result_ready,
  output id_t        result_id,
  output logic [4:0] result_rd,
  output logic       result_we,
  output word_t      result_data,
  input  addr_t      load_addr,
  input  addr_t      store_addr,
  input  word_t      load_data,
  input  window_t    store_window,
  output logic       cfg_we,
  output logic       rd_lo_we,
  output logic       rd_hi_we,
  output logic       shadow_we,
  output instr_u     instr,
  output word_t      rs1,
  output word_t      rs2
);

  stream_state_e state_q;
  stream_state_e state_d;
  instr_u        instr_q;
  word_t         rs1_q;
  word_t         rs2_q;
  id_t           id_q;
  logic          commit_seen_q;   // sticky until the instruction leaves
  logic          issue_fire;
  logic          kill;
  logic          commit_ok;
  logic          committed;
  logic          is_load;
  logic          word_hi;         // high word of the window
  addr_t         base_addr;

  function automatic logic is_cfg(instr_u w);
    logic [2:0] f3;
    f3 = w.cfg.funct3;
    return f3[`BS_F3_CFG_BIT];
  endfunction

  assign issue_accept    = (issue_instr.op.opcode == RMLD) || (issue_instr.op.opcode == RMST);
  assign issue_writeback = (issue_instr.op.opcode == RMLD) && !is_cfg(issue_instr);
  assign issue_ready     = state_q == IDLE;
  assign issue_fire      = issue_valid && issue_ready && issue_accept;

  assign kill      = commit_valid && commit_kill;
  assign commit_ok = commit_valid && !commit_kill;
  assign committed = commit_seen_q || commit_ok;

  // while idle the issue operands go straight through, so a configuration
  // committed in its own issue cycle writes the bases on that edge
  assign instr   = (state_q == IDLE) ? issue_instr : instr_q;
  assign rs1     = (state_q == IDLE) ? issue_rs1 : rs1_q;
  assign rs2     = (state_q == IDLE) ? issue_rs2 : rs2_q;
  assign is_load = (instr.op.opcode == RMLD) && !is_cfg(instr);

  always_ff @(posedge clk_i) begin
    if (issue_fire) begin
      instr_q <= issue_instr;
      rs1_q   <= issue_rs1;
      rs2_q   <= issue_rs2;
      id_q    <= issue_id;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q       <= IDLE;
      commit_seen_q <= 1'b0;
    end else begin
      state_q <= state_d;
      if (state_d == IDLE) begin
        commit_seen_q <= 1'b0;
      end else if (commit_ok) begin
        commit_seen_q <= 1'b1;
      end
    end
  end

  always_comb begin
    state_d = state_q;
    if (kill && state_q != IDLE) begin
      state_d = IDLE;                          // kill wins over everything
    end else begin
      case (state_q)
        IDLE: begin
          if (issue_fire && !kill) begin
            if (is_cfg(issue_instr)) begin
              state_d = commit_ok ? RETIRE : CFG;
            end else begin
              state_d = RD_LO;
            end
          end
        end
        CFG: begin
          if (committed) begin
            state_d = RETIRE;
          end
        end
        RD_LO: begin
          if (mem_result_valid) begin
            state_d = RD_HI;
          end
        end
        RD_HI: begin
          if (mem_result_valid) begin
            if (!committed) begin
              state_d = WAIT_COMMIT;
            end else begin
              state_d = is_load ? RETIRE : WR_LO;
            end
          end
        end
        WAIT_COMMIT: begin
          if (committed) begin
            state_d = is_load ? RETIRE : WR_LO;
          end
        end
        WR_LO: begin
          if (mem_result_valid) begin
            state_d = WR_HI;
          end
        end
        WR_HI: begin
          if (mem_result_valid) begin
            state_d = RETIRE;
          end
        end
        RETIRE: begin
          if (result_ready) begin
            state_d = IDLE;
          end
        end
        default: begin
          state_d = IDLE;
        end
      endcase
    end
  end

  assign cfg_we    = is_cfg(instr) && (state_d == RETIRE) && (state_q inside {IDLE, CFG});
  assign rd_lo_we  = (state_q == RD_LO) && mem_result_valid && !kill;
  assign rd_hi_we  = (state_q == RD_HI) && mem_result_valid && !kill;
  assign shadow_we = (state_q == RETIRE) && result_ready && is_load;  // updated at retirement

  assign word_hi   = state_q inside {RD_HI, WR_HI};
  assign base_addr = is_load ? load_addr : store_addr;

  assign mem_valid = state_q inside {RD_LO, RD_HI, WR_LO, WR_HI};
  assign mem_we    = state_q inside {WR_LO, WR_HI};
  assign mem_addr  = word_hi ? base_addr + addr_t'(`BS_WORD_BYTES) : base_addr;
  assign mem_wdata = word_hi ? store_window[2*`BS_XLEN-1:`BS_XLEN]
                             : store_window[`BS_XLEN-1:0];
  assign mem_last  = ((state_q == RD_HI) && is_load) || (state_q == WR_HI);

  assign result_valid = state_q == RETIRE;
  assign result_id    = id_q;
  assign result_rd    = instr_q.op.rd;
  assign result_we    = result_valid && is_load;
  assign result_data  = result_we ? load_data : '0;   // buffer is stable while retiring

endmodule

/* logic/stream_base_regs.sv */
`timescale 1ns/1ps

module stream_base_regs import bitstream_pkg::*; (
  input  logic   clk_i,
  input  logic   rst_ni,
  input  logic   cfg_we,       // committed configuration instruction
  input  instr_u instr,
  input  word_t  rs1,
  input  word_t  rs2,
  output addr_t  load_addr,
  output addr_t  store_addr
);

  addr_t load_base_q;
  addr_t store_base_q;
  addr_t word_offset;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      load_base_q  <= '0;
      store_base_q <= '0;
    end else if (cfg_we) begin
      case (instr.cfg.funct3)
        CASRM: begin
          store_base_q <= rs1;
        end
        CALRM: begin
          load_base_q <= rs2;
        end
        CASLRM: begin
          store_base_q <= rs1;
          load_base_q  <= rs2;
        end
        default: ;
      endcase
    end
  end

  // the upper bits of the bit offset count whole words past the base
  assign word_offset = {3'b000, rs1[31:5], 2'b00};

  assign load_addr  = load_base_q + word_offset;
  assign store_addr = store_base_q + word_offset;

endmodule

/* logic/bitfield_datapath.sv */
`timescale 1ns/1ps
`include "bitstream_config.svh"

module bitfield_datapath import bitstream_pkg::*; (
  input  logic    clk_i,
  input  logic    rst_ni,
  input  logic    rd_lo_we,      // first read completes
  input  logic    rd_hi_we,      // second read completes
  input  logic    shadow_we,
  input  word_t   mem_rdata,
  input  instr_u  instr,
  input  word_t   rs1,
  input  word_t   rs2,
  output word_t   load_data,
  output window_t store_window
);

  window_t    rd_buf;
  word_t      shadow_q;
  bit_idx_t   bit_idx;
  logic [5:0] field_len;         // 1 to 32
  window_t    len_mask;          // field_len ones at the bottom
  window_t    field_mask;        // len_mask moved up to the field position
  window_t    shifted;
  window_t    fill;

  assign bit_idx   = rs1[4:0];
  assign field_len = {1'b0, rs2[4:0]} + 6'd1;

  always_ff @(posedge clk_i) begin
    if (rd_lo_we) begin
      rd_buf[`BS_XLEN-1:0] <= mem_rdata;
    end
    if (rd_hi_we) begin
      rd_buf[2*`BS_XLEN-1:`BS_XLEN] <= mem_rdata;
    end
  end

  // the shadow register holds the last load's unmasked shifted word
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      shadow_q <= '0;
    end else if (shadow_we) begin
      shadow_q <= shifted[`BS_XLEN-1:0];
    end
  end

  assign len_mask   = ~({(2*`BS_XLEN){1'b1}} << field_len);
  assign field_mask = len_mask << bit_idx;
  assign shifted    = rd_buf >> bit_idx;

  assign load_data = shifted[`BS_XLEN-1:0] & len_mask[`BS_XLEN-1:0];

  always_comb begin
    case (instr.op.funct3)
      RMXR:    fill = '0;
      RMXS:    fill = '1;
      RMCS:    fill = window_t'(shadow_q) << bit_idx;  // shadow bit k lands on bit_idx + k
      default: fill = '0;
    endcase
  end

  // bits outside the field pass through from the read window
  assign store_window = (rd_buf & ~field_mask) | (fill & field_mask);

endmodule

/* logic/bitstream_pkg.sv */
`include "bitstream_config.svh"

package bitstream_pkg;

  typedef logic [`BS_XLEN-1:0]         word_t;
  typedef logic [`BS_XLEN-1:0]         addr_t;
  typedef logic [2*`BS_XLEN-1:0]       window_t;   // low word at the lower address
  typedef logic [`BS_ID_WIDTH-1:0]     id_t;
  typedef logic [$clog2(`BS_XLEN)-1:0] bit_idx_t;  // bit position or length minus one

  typedef enum logic [6:0] {
    RMLD = `BS_OPCODE_RMLD,
    RMST = `BS_OPCODE_RMST
  } opcode_e;

  typedef enum logic [2:0] {
    CASRM  = `BS_F3_CASRM,
    CALRM  = `BS_F3_CALRM,
    CASLRM = `BS_F3_CASLRM
  } cfg_funct3_e;

  typedef enum logic [2:0] {
    RMXR = `BS_F3_RMXR,
    RMXS = `BS_F3_RMXS,
    RMCS = `BS_F3_RMCS
  } fill_funct3_e;

  typedef enum logic [2:0] {
    IDLE,
    CFG,
    RD_LO,
    RD_HI,
    WAIT_COMMIT,
    WR_LO,
    WR_HI,
    RETIRE
  } stream_state_e;

  typedef struct packed {
    logic [6:0]  funct7;
    logic [4:0]  rs2;
    logic [4:0]  rs1;
    cfg_funct3_e funct3;
    logic [4:0]  rd;
    opcode_e     opcode;
  } cfg_instr_t;

  typedef struct packed {
    logic [6:0]   funct7;
    logic [4:0]   rs2;
    logic [4:0]   rs1;
    fill_funct3_e funct3;   // fill mode, only meaningful on RMST
    logic [4:0]   rd;
    opcode_e      opcode;
  } op_instr_t;

  typedef union packed {
    cfg_instr_t cfg;
    op_instr_t  op;
  } instr_u;

endpackage

/* logic/bitstream_config.svh */
`ifndef BITSTREAM_CONFIG_SVH
`define BITSTREAM_CONFIG_SVH

`define BS_XLEN          32
`define BS_ID_WIDTH      4
`define BS_WORD_BYTES    4            // byte step to the high word of a window

`define BS_OPCODE_RMLD   7'b000_1011  // custom-0
`define BS_OPCODE_RMST   7'b010_1011  // custom-1

// funct3 bit 2 marks a configuration instruction on either opcode
`define BS_F3_CFG_BIT    2
`define BS_F3_CASRM      3'b101       // store base from rs1
`define BS_F3_CALRM      3'b110       // load base from rs2
`define BS_F3_CASLRM     3'b111       // both bases

`define BS_F3_RMXR       3'b000       // fill with zeros
`define BS_F3_RMXS       3'b001       // fill with ones
`define BS_F3_RMCS       3'b010       // fill from shadow register

`endif
